// ==== hdl/cargo_pkg.sv ====
package cargo_pkg;

    // Car store size
    localparam int num_slots = 8;

    typedef logic [$clog2(num_slots)-1:0] slot_addr_t;

    // One extra bit so a full store (8) fits
    typedef logic [$clog2(num_slots):0] slot_count_t;

    typedef enum logic [1:0] {
        crate,
        parcel,
        trolley,
        bin
    } obj_kind_e;

    // One object in the car
    typedef struct packed {
        logic               valid;
        obj_kind_e          kind;
        motion_pkg::floor_t dest;
    } cargo_obj_t;

    // Report of one stop
    typedef struct packed {
        motion_pkg::floor_t floor;
        slot_count_t        unloaded;
    } arrival_t;

    // Command word from outside, obj only matters for op_load
    typedef struct packed {
        motion_pkg::cmd_op_e op;
        cargo_obj_t          obj;
    } car_cmd_t;

endpackage

// ==== hdl/elevator_car_ctrl.sv ====
module elevator_car_ctrl (
    input  logic                   clk,
    input  logic                   clear,
    input  logic                   cmd_strobe,
    input  cargo_pkg::car_cmd_t    cmd,
    input  cargo_pkg::cargo_obj_t  head_obj,
    output logic                   load_strobe,
    output cargo_pkg::cargo_obj_t  load_obj,
    output logic                   unload_strobe,
    output motion_pkg::floor_t     unload_floor,
    output motion_pkg::floor_t     cur_floor,
    output logic                   busy
);

    import motion_pkg::*;

    car_state_e state;
    timer_t     timer;
    floor_t     next_floor;
    logic       run_accept;
    logic       at_target;

    // Commands are only taken while the car stands idle
    assign load_strobe = cmd_strobe && (cmd.op == op_load) && (state == idle);
    assign load_obj    = cmd.obj;

    // A run with an empty car is dropped
    assign run_accept = cmd_strobe && (cmd.op == op_run) && (state == idle)
                        && head_obj.valid;

    // Target is always the oldest object on board
    assign at_target  = (cur_floor == head_obj.dest);
    assign next_floor = (head_obj.dest > cur_floor) ? cur_floor + 1'b1
                                                    : cur_floor - 1'b1;

    assign unload_floor = cur_floor;
    assign busy         = (state != idle);

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            state         <= idle;
            timer         <= '0;
            cur_floor     <= '0;
            unload_strobe <= 1'b0;
        end else begin
            unload_strobe <= 1'b0;
            case (state)
                idle: begin
                    if (run_accept) begin
                        timer <= '0;
                        if (at_target) begin
                            state         <= door_open;
                            unload_strobe <= 1'b1;
                        end else begin
                            state <= moving;
                        end
                    end
                end
                moving: begin
                    if (at_target) begin
                        // Arrived, open the door and unload this floor
                        state         <= door_open;
                        unload_strobe <= 1'b1;
                        timer         <= '0;
                    end else if (timer == timer_t'(floor_cycles - 1)) begin
                        timer     <= '0;
                        cur_floor <= next_floor;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                door_open: begin
                    if (timer == timer_t'(door_cycles - 1)) begin
                        timer <= '0;
                        // Head slot already shows the survivors here
                        state <= head_obj.valid ? moving : idle;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    a_floor_step: assert property (
        @(posedge clk) disable iff (clear)
        !$stable(cur_floor) |->
            (int'(cur_floor) == int'($past(cur_floor)) + 1) ||
            (int'(cur_floor) + 1 == int'($past(cur_floor)))
    );

    a_floor_moves_only_moving: assert property (
        @(posedge clk) disable iff (clear)
        !$stable(cur_floor) |-> ($past(state) == moving)
    );

    a_unload_on_entry: assert property (
        @(posedge clk) disable iff (clear)
        unload_strobe |-> (state == door_open) && ($past(state) != door_open)
    );

endmodule

// ==== hdl/elevator_cargo_store.sv ====
module elevator_cargo_store (
    input  logic                   clk,
    input  logic                   clear,
    input  logic                   load_strobe,
    input  cargo_pkg::cargo_obj_t  load_obj,
    input  logic                   unload_strobe,
    input  motion_pkg::floor_t     unload_floor,
    input  cargo_pkg::slot_addr_t  read_addr,
    output cargo_pkg::cargo_obj_t  read_slot,
    output cargo_pkg::cargo_obj_t  head_obj,
    output logic                   has_room,
    output logic                   arrival_strobe,
    output cargo_pkg::arrival_t    arrival
);

    import cargo_pkg::*;
    import motion_pkg::*;

    // Slots kept in load order, valid ones always packed from slot 0
    cargo_obj_t  slots [num_slots];
    cargo_obj_t  kept [num_slots];
    slot_count_t occupied;
    slot_count_t removed;
    logic        gap_found;

    function automatic logic bound_for(cargo_obj_t obj, floor_t fl);
        return obj.valid && (obj.dest == fl);
    endfunction

    // Occupancy, and a check that no invalid slot sits below a valid one
    always_comb begin
        occupied  = '0;
        gap_found = 1'b0;
        for (int i = 0; i < num_slots; i++) begin
            if (slots[i].valid)
                occupied = occupied + 1'b1;
        end
        for (int i = 0; i < num_slots - 1; i++) begin
            if (slots[i + 1].valid && !slots[i].valid)
                gap_found = 1'b1;
        end
    end

    // Survivors of an unload, compacted toward slot 0
    always_comb begin
        slot_count_t kept_n;
        kept   = '{default: '0};
        kept_n = '0;
        for (int i = 0; i < num_slots; i++) begin
            if (slots[i].valid && !bound_for(slots[i], unload_floor)) begin
                kept[slot_addr_t'(kept_n)] = slots[i];
                kept_n = kept_n + 1'b1;
            end
        end
        removed = occupied - kept_n;
    end

    assign has_room = (occupied < slot_count_t'(num_slots));
    assign head_obj = slots[0];

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            slots          <= '{default: '0};
            read_slot      <= '0;
            arrival_strobe <= 1'b0;
        end else begin
            if (unload_strobe) begin
                slots <= kept;
            end else if (load_strobe && has_room) begin
                // Next free slot is at the occupied count
                slots[slot_addr_t'(occupied)] <= '{
                    valid: 1'b1,
                    kind:  load_obj.kind,
                    dest:  load_obj.dest
                };
            end
            read_slot      <= slots[read_addr];
            arrival_strobe <= unload_strobe;
        end
    end

    // Stop report payload, qualified by arrival_strobe
    always_ff @(posedge clk) begin
        if (unload_strobe) begin
            arrival.floor    <= unload_floor;
            arrival.unloaded <= removed;
        end
    end

    // Controller loads only while idle and unloads only on a stop
    a_no_load_unload: assert property (
        @(posedge clk) disable iff (clear)
        !(load_strobe && unload_strobe)
    );

    a_slots_packed: assert property (
        @(posedge clk) disable iff (clear)
        !gap_found
    );

endmodule

// ==== hdl/elevator_top.sv ====
module elevator_top (
    input  logic                   clk,
    input  logic                   clear,
    input  logic                   cmd_strobe,
    input  cargo_pkg::car_cmd_t    cmd,
    input  cargo_pkg::slot_addr_t  read_addr,
    output cargo_pkg::cargo_obj_t  read_slot,
    output logic                   has_room,
    output motion_pkg::floor_t     cur_floor,
    output logic                   busy,
    output logic                   arrival_strobe,
    output cargo_pkg::arrival_t    arrival
);

    import cargo_pkg::*;
    import motion_pkg::*;

    logic       load_strobe;
    cargo_obj_t load_obj;
    logic       unload_strobe;
    floor_t     unload_floor;
    cargo_obj_t head_obj;

    elevator_car_ctrl u_ctrl (
        .clk           (clk),
        .clear         (clear),
        .cmd_strobe    (cmd_strobe),
        .cmd           (cmd),
        .head_obj      (head_obj),
        .load_strobe   (load_strobe),
        .load_obj      (load_obj),
        .unload_strobe (unload_strobe),
        .unload_floor  (unload_floor),
        .cur_floor     (cur_floor),
        .busy          (busy)
    );

    elevator_cargo_store u_store (
        .clk            (clk),
        .clear          (clear),
        .load_strobe    (load_strobe),
        .load_obj       (load_obj),
        .unload_strobe  (unload_strobe),
        .unload_floor   (unload_floor),
        .read_addr      (read_addr),
        .read_slot      (read_slot),
        .head_obj       (head_obj),
        .has_room       (has_room),
        .arrival_strobe (arrival_strobe),
        .arrival        (arrival)
    );

endmodule

// ==== hdl/motion_pkg.sv ====
package motion_pkg;

    // Building size
    localparam int num_floors = 4;

    typedef logic [$clog2(num_floors)-1:0] floor_t;

    // Travel timing, in clock cycles
    localparam int floor_cycles = 4;
    localparam int door_cycles  = 3;

    // Shared timer covers the longer of the two intervals
    localparam int timer_width =
        $clog2(floor_cycles > door_cycles ? floor_cycles : door_cycles);

    typedef logic [timer_width-1:0] timer_t;

    // Car motion
    typedef enum logic [1:0] {
        idle,
        moving,
        door_open
    } car_state_e;

    // Command opcode
    typedef enum logic {
        op_load,
        op_run
    } cmd_op_e;

endpackage

// ==== project.f ====
hdl/motion_pkg.sv
hdl/cargo_pkg.sv
hdl/elevator_cargo_store.sv
hdl/elevator_car_ctrl.sv
hdl/elevator_top.sv
verif/clock_gen.sv
verif/elevator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module elevator_tb -f project.f &&
./obj_dir/Velevator_tb | tee /dev/stderr | grep -q "TEST OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== verif/clock_gen.sv ====
module clock_gen (
    output logic clk,
    output logic clear
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period  = 5;
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Release clear on a falling edge, away from the DUT's active edge
    initial begin
        clear = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        clear = 1'b0;
    end

endmodule

// ==== verif/elevator_golden.txt ====
# L loads, R run + busy after, S slots 0-7, H has_room, A arrival floor count, F idle floor
# Objects are hex {valid, kind, dest}, 00 means no object
S 00 00 00 00 00 00 00 00
H 1
L 12 15 1a
S 12 15 1a 00 00 00 00 00
L 1f
R 1
L 10
R 1
A 2 2
A 1 1
A 3 1
F 3
S 00 00 00 00 00 00 00 00
R 0
F 3
L 10 14 18 1c 10 14 18 1c
H 0
L 11
S 10 14 18 1c 10 14 18 1c
R 1
A 0 8
F 0
S 00 00 00 00 00 00 00 00
H 1
L 10
R 1
A 0 1
F 0

// ==== verif/elevator_tb.sv ====
module elevator_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cargo_pkg::*;
    import motion_pkg::*;

    localparam string golden_path = "verif/elevator_golden.txt";
    localparam int    clk_period  = 10;

    logic       clk;
    logic       clear;
    logic       cmd_strobe;
    car_cmd_t   cmd;
    slot_addr_t read_addr;
    cargo_obj_t read_slot;
    logic       has_room;
    floor_t     cur_floor;
    logic       busy;
    logic       arrival_strobe;
    arrival_t   arrival;

    string      records [$];
    arrival_t   seen [$];
    arrival_t   expected [$];
    int         value_errors;
    int         other_errors;
    logic       loaded;

    clock_gen u_clk (
        .clk   (clk),
        .clear (clear)
    );

    elevator_top uut (.*);

    // Every stop report, in the order the car makes them
    always @(negedge clk) begin
        if (!clear && arrival_strobe)
            seen.push_back(arrival);
    end

    task automatic check_obj(string name, cargo_obj_t exp, cargo_obj_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_arrival(string name, arrival_t exp, arrival_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %0t %s expected floor %0d count %0d actual floor %0d count %0d",
                     $time, name, exp.floor, exp.unloaded, act.floor, act.unloaded);
        end
    endtask

    task automatic check_floor(string name, floor_t exp, floor_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // One-cycle strobe, set up and removed on falling edges
    task automatic send_cmd(cmd_op_e op, cargo_obj_t obj);
        @(negedge clk);
        cmd_strobe = 1'b1;
        cmd.op     = op;
        cmd.obj    = obj;
        @(negedge clk);
        cmd_strobe = 1'b0;
    endtask

    // Waits out the trip, then matches stop reports against the records
    task automatic finish_trip(floor_t exp_floor);
        arrival_t exp_a;
        arrival_t act_a;
        while (busy)
            @(negedge clk);
        while (expected.size() > 0) begin
            exp_a = expected.pop_front();
            if (seen.size() == 0) begin
                other_errors++;
                $display("Missing arrival at floor %0d with %0d objects",
                         exp_a.floor, exp_a.unloaded);
            end else begin
                check_arrival("arrival", exp_a, seen.pop_front());
            end
        end
        while (seen.size() > 0) begin
            act_a = seen.pop_front();
            other_errors++;
            $display("Unexpected arrival at floor %0d with %0d objects",
                     act_a.floor, act_a.unloaded);
        end
        check_floor("cur_floor", exp_floor, cur_floor);
    endtask

    task automatic run_record(string line);
        string    code;
        int       v [num_slots];
        arrival_t a;
        v = '{default: 0};
        void'($sscanf(line, "%s %h %h %h %h %h %h %h %h", code,
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]));
        case (code)
            "L": begin
                // Unused columns stay zero and carry no object
                for (int i = 0; i < num_slots; i++) begin
                    if (v[i][4])
                        send_cmd(op_load, cargo_obj_t'(v[i][4:0]));
                end
            end
            "R": begin
                send_cmd(op_run, '0);
                check_flag("busy", v[0][0], busy);
            end
            "S": begin
                for (int i = 0; i < num_slots; i++) begin
                    read_addr = slot_addr_t'(i);
                    @(negedge clk);
                    check_obj($sformatf("read_slot[%0d]", i), cargo_obj_t'(v[i][4:0]),
                              read_slot);
                end
            end
            "H": check_flag("has_room", v[0][0], has_room);
            "A": begin
                a.floor    = floor_t'(v[0][1:0]);
                a.unloaded = slot_count_t'(v[1][3:0]);
                expected.push_back(a);
            end
            "F": finish_trip(floor_t'(v[0][1:0]));
            default: begin
                other_errors++;
                $display("Unknown record in golden file: %s", line);
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        cmd_strobe   = 1'b0;
        cmd          = '0;
        read_addr    = '0;
        value_errors = 0;
        other_errors = 0;
        loaded       = 1'b0;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open golden file %s", golden_path);
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#")
                    records.push_back(line);
            end
            $fclose(fd);
        end
        loaded = (records.size() > 0);
        wait (!clear);
        foreach (records[i])
            run_record(records[i]);
        @(negedge clk);
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Limit scales with the number of records and the longest possible trip
    initial begin
        wait (loaded);
        #(records.size() * num_floors * (floor_cycles + door_cycles) * clk_period * 4);
        $display("Watchdog expired before all golden records were processed");
        $display("TEST FAILED");
        $finish;
    end

endmodule
